/* panel_consts.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sensor panel constants
// bus timing, scan and debounce lengths, adc address, register map
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PANEL_CONSTS_SVH
`define PANEL_CONSTS_SVH

// sys_clk cycles per quarter scl period
`define I2C_DIV          4
// gap between the end of one read and the next start
`define POLL_CYCLES      200
`define DEBOUNCE_CYCLES  16
`define SCAN_CYCLES      8

`define ADC_DEV_ADDR     7'h54

// register byte offsets
`define REG_CTRL         16'h0000
`define REG_DISP_LO      16'h0004
`define REG_DISP_HI      16'h0008
`define REG_SAMPLE       16'h000C
`define REG_STATUS       16'h0010

`endif

/* i2c_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c types: reader phases, pin enables and the adc sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package i2c_pkg;
	// one bit slot is four quarters
	typedef enum logic [2:0] {
		I2C_IDLE,
		I2C_START,
		I2C_ADDR,
		I2C_DATA,
		I2C_STOP
	} i2c_state_t;

	typedef struct packed {
		logic [7:0] raw;
		logic       nack;
		logic       done;
	} adc_sample_t;

	// high means pull the line low
	typedef struct packed {
		logic scl_oe;
		logic sda_oe;
	} i2c_pins_t;
endpackage

`default_nettype wire

/* panel_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel types: axi4-lite channels, control, display word, digits
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package panel_pkg;
	typedef struct packed {
		logic [15:0] awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [15:0] araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	// poll_en is bit 0
	typedef struct packed {
		logic raw_seg;
		logic show_user;
		logic poll_en;
	} ctrl_t;

	typedef struct packed {
		logic       blank;
		logic [2:0] rsvd;
		logic [3:0] nib;
	} disp_hex_t;

	// digit 0 lives in the low byte
	typedef union packed {
		disp_hex_t [7:0]  hex;
		logic [7:0][7:0]  seg;
	} disp_word_u;

	typedef struct packed {
		logic [3:0] hun;
		logic [3:0] ten;
		logic [3:0] uni;
	} bcd3_t;

	typedef logic [3:0] key_evt_t;
endpackage

`default_nettype wire

/* i2c_adc_reader.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// i2c adc reader
// polls one byte from the adc, open-drain enables, ack check
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "panel_consts.svh"

module i2c_adc_reader
	import i2c_pkg::*;
(
	input  wire         sys_clk,
	input  wire         sys_rst_n,
	input  wire         poll_en,
	input  wire         sda_in,
	output i2c_pins_t   pins,
	output adc_sample_t sample
);

	i2c_state_t  state;
	logic [15:0] div_cnt;
	logic [1:0]  quarter;
	logic [3:0]  bit_cnt;
	logic [31:0] poll_cnt;
	logic [7:0]  tx_shift;
	logic [7:0]  rx_shift;
	logic        nack_seen;
	logic [1:0]  sda_sync;
	logic        qtick;
	logic        scl_low;
	logic        sda_low;

	assign qtick = (div_cnt == 16'(`I2C_DIV - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sda_sync <= 2'b11;
		end else begin
			sda_sync <= {sda_sync[0], sda_in};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= I2C_IDLE;
			div_cnt   <= '0;
			quarter   <= '0;
			bit_cnt   <= '0;
			poll_cnt  <= '0;
			nack_seen <= 1'b0;
			sample    <= '0;
		end else begin
			sample.done <= 1'b0;
			if (state == I2C_IDLE) begin
				div_cnt   <= '0;
				quarter   <= '0;
				nack_seen <= 1'b0;
				if (!poll_en) begin
					poll_cnt <= '0;
				end else if (poll_cnt == 32'(`POLL_CYCLES - 1)) begin
					poll_cnt <= '0;
					state    <= I2C_START;
				end else begin
					poll_cnt <= poll_cnt + 32'd1;
				end
			end else begin
				div_cnt <= qtick ? '0 : div_cnt + 16'd1;
				if (qtick) begin
					quarter <= quarter + 2'd1;
					// slave ack sits on the ninth address bit
					if (quarter == 2'd2 && state == I2C_ADDR && bit_cnt == 4'd8)
						nack_seen <= sda_sync[1];
					if (quarter == 2'd3) begin
						case (state)
							I2C_START: begin
								state   <= I2C_ADDR;
								bit_cnt <= '0;
							end
							I2C_ADDR: begin
								if (bit_cnt == 4'd8) begin
									state   <= nack_seen ? I2C_STOP : I2C_DATA;
									bit_cnt <= '0;
								end else begin
									bit_cnt <= bit_cnt + 4'd1;
								end
							end
							I2C_DATA: begin
								if (bit_cnt == 4'd8)
									state <= I2C_STOP;
								else
									bit_cnt <= bit_cnt + 4'd1;
							end
							I2C_STOP: begin
								state       <= I2C_IDLE;
								sample.done <= 1'b1;
								sample.nack <= nack_seen;
								if (!nack_seen)
									sample.raw <= rx_shift;
							end
							default: state <= I2C_IDLE;
						endcase
					end
				end
			end
		end
	end

	// address shifts out msb first, ones fill in behind it
	always_ff @(posedge sys_clk) begin
		if (state == I2C_IDLE)
			tx_shift <= {`ADC_DEV_ADDR, 1'b1};
		else if (qtick && quarter == 2'd3 && state == I2C_ADDR)
			tx_shift <= {tx_shift[6:0], 1'b1};
		if (qtick && quarter == 2'd2 && state == I2C_DATA && bit_cnt < 4'd8)
			rx_shift <= {rx_shift[6:0], sda_sync[1]};
	end

	// scl low in quarters 0 and 3 of a bit, sda moves while scl is low
	always_comb begin
		scl_low = 1'b0;
		sda_low = 1'b0;
		case (state)
			I2C_START: begin
				sda_low = (quarter != 2'd0);
				scl_low = (quarter == 2'd3);
			end
			I2C_ADDR, I2C_DATA: begin
				scl_low = (quarter == 2'd0) || (quarter == 2'd3);
				sda_low = ~tx_shift[7];
			end
			I2C_STOP: begin
				scl_low = (quarter == 2'd0);
				sda_low = (quarter < 2'd2);
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			pins <= '0;
		else
			pins <= '{scl_oe: scl_low, sda_oe: sda_low};
	end

endmodule

`default_nettype wire

/* reading_to_bcd.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte to three bcd digits, one double-dabble step per cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module reading_to_bcd
	import panel_pkg::*;
(
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire [7:0]  raw,
	input  wire        start,
	output bcd3_t      bcd,
	output logic       valid
);

	// digits in 19:8, binary in 7:0
	logic [19:0] work;
	logic [19:0] adj;
	logic [2:0]  step;
	logic        busy;

	always_comb begin
		adj = work;
		for (int d = 0; d < 3; d++) begin
			if (work[8 + 4*d +: 4] >= 4'd5)
				adj[8 + 4*d +: 4] = work[8 + 4*d +: 4] + 4'd3;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy  <= 1'b0;
			step  <= '0;
			valid <= 1'b0;
		end else begin
			valid <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 3'd1;
				if (step == 3'd7) begin
					busy  <= 1'b0;
					valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start)
			work <= {12'd0, raw};
		else if (busy)
			work <= {adj[18:0], 1'b0};
		// last shift lands straight in the output
		if (busy && !start && step == 3'd7)
			bcd <= adj[18:7];
	end

endmodule

`default_nettype wire

/* key_debounce.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-key debouncer, one-cycle press pulse on an accepted low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "panel_consts.svh"

module key_debounce
	import panel_pkg::*;
(
	input  wire       sys_clk,
	input  wire       sys_rst_n,
	input  wire [3:0] key_in,
	output key_evt_t  press
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

	logic [3:0]       sync_a;
	logic [3:0]       sync_b;
	// accepted key levels, released is high
	logic [3:0]       level;
	logic [CNT_W-1:0] cnt [4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_a <= 4'hf;
			sync_b <= 4'hf;
			level  <= 4'hf;
			press  <= '0;
			for (int k = 0; k < 4; k++)
				cnt[k] <= '0;
		end else begin
			sync_a <= key_in;
			sync_b <= sync_a;
			press  <= '0;
			for (int k = 0; k < 4; k++) begin
				if (sync_b[k] == level[k]) begin
					cnt[k] <= '0;
				end else if (cnt[k] == CNT_W'(`DEBOUNCE_CYCLES - 1)) begin
					cnt[k]   <= '0;
					level[k] <= sync_b[k];
					press[k] <= ~sync_b[k];
				end else begin
					cnt[k] <= cnt[k] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* seg_scan.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// eight-digit display scan
// decimal reading, user hex nibbles or raw segment bytes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "panel_consts.svh"

module seg_scan
	import panel_pkg::*;
(
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire ctrl_t      ctrl,
	input  wire disp_word_u user_word,
	input  wire bcd3_t      reading,
	output logic [7:0]      seg_number,
	output logic [7:0]      seg_choice
);

	localparam int SCAN_W = $clog2(`SCAN_CYCLES + 1);

	logic [SCAN_W-1:0] scan_cnt;
	logic [2:0]        digit;

	// active low segments, dp off
	function automatic logic [7:0] hex_seg(input logic [3:0] nib);
		case (nib)
			4'h0: return 8'hc0;
			4'h1: return 8'hf9;
			4'h2: return 8'ha4;
			4'h3: return 8'hb0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hf8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'ha: return 8'h88;
			4'hb: return 8'h83;
			4'hc: return 8'hc6;
			4'hd: return 8'ha1;
			4'he: return 8'h86;
			default: return 8'h8e;
		endcase
	endfunction

	// counter starts full so digit 0 comes up on the first edge
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			scan_cnt   <= SCAN_W'(`SCAN_CYCLES - 1);
			digit      <= 3'd7;
			seg_choice <= 8'hff;
		end else if (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1)) begin
			scan_cnt   <= '0;
			digit      <= digit + 3'd1;
			seg_choice <= (seg_choice == 8'hff) ? 8'hfe : {seg_choice[6:0], seg_choice[7]};
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_comb begin
		seg_number = 8'hff;
		if (!ctrl.show_user) begin
			case (digit)
				3'd0: seg_number = hex_seg(reading.uni);
				3'd1: seg_number = hex_seg(reading.ten);
				// no leading zero on the hundreds
				3'd2: seg_number = (reading.hun == 4'd0) ? 8'hff : hex_seg(reading.hun);
				default: seg_number = 8'hff;
			endcase
		end else if (ctrl.raw_seg) begin
			seg_number = user_word.seg[digit];
		end else if (!user_word.hex[digit].blank) begin
			seg_number = hex_seg(user_word.hex[digit].nib);
		end
	end

endmodule

`default_nettype wire

/* panel_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel register block, axi4-lite slave
// control, display word, latest sample, sticky key and nack status
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "panel_consts.svh"

module panel_regs
	import i2c_pkg::*;
	import panel_pkg::*;
(
	input  wire              sys_clk,
	input  wire              sys_rst_n,
	input  wire axil_req_t   axil_req,
	output axil_rsp_t        axil_rsp,
	input  wire adc_sample_t sample,
	input  wire bcd3_t       bcd,
	input  wire              bcd_valid,
	input  wire key_evt_t    press,
	output ctrl_t            ctrl,
	output disp_word_u       user_word,
	output bcd3_t            reading
);

	logic [31:0] disp_lo;
	logic [31:0] disp_hi;
	logic [7:0]  raw_q;
	logic [3:0]  key_sts;
	logic        nack_sts;
	logic        bvalid_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic        wr_acc;
	logic        rd_acc;
	logic        sts_wr;
	logic [31:0] ctrl_new;
	logic [31:0] clr_bits;
	logic [31:0] rd_mux;

	function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
		input logic [31:0] new_val, input logic [3:0] strb);
		logic [31:0] res;
		for (int b = 0; b < 4; b++)
			res[8*b +: 8] = strb[b] ? new_val[8*b +: 8] : old_val[8*b +: 8];
		return res;
	endfunction

	// one transaction in flight at a time
	assign wr_acc = axil_req.awvalid & axil_req.wvalid & ~bvalid_q & ~rvalid_q;
	assign rd_acc = axil_req.arvalid & ~bvalid_q & ~rvalid_q;

	assign sts_wr   = wr_acc && (axil_req.awaddr == `REG_STATUS);
	assign ctrl_new = apply_strb({29'd0, ctrl}, axil_req.wdata, axil_req.wstrb);
	assign clr_bits = sts_wr ? apply_strb(32'd0, axil_req.wdata, axil_req.wstrb) : 32'd0;

	assign user_word = {disp_hi, disp_lo};
	assign axil_rsp  = '{awready: wr_acc, wready: wr_acc, bvalid: bvalid_q, bresp: 2'b00,
		arready: rd_acc, rvalid: rvalid_q, rdata: rdata_q, rresp: 2'b00};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ctrl     <= '0;
			disp_lo  <= '0;
			disp_hi  <= '0;
			raw_q    <= '0;
			reading  <= '0;
			key_sts  <= '0;
			nack_sts <= 1'b0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_acc)
				bvalid_q <= 1'b1;
			else if (axil_req.bready)
				bvalid_q <= 1'b0;
			if (rd_acc)
				rvalid_q <= 1'b1;
			else if (axil_req.rready)
				rvalid_q <= 1'b0;
			if (wr_acc) begin
				case (axil_req.awaddr)
					`REG_CTRL:    ctrl <= ctrl_new[2:0];
					`REG_DISP_LO: disp_lo <= apply_strb(disp_lo, axil_req.wdata, axil_req.wstrb);
					`REG_DISP_HI: disp_hi <= apply_strb(disp_hi, axil_req.wdata, axil_req.wstrb);
					default: ;
				endcase
			end
			// raw byte only from an acknowledged read
			if (sample.done && !sample.nack)
				raw_q <= sample.raw;
			if (bcd_valid)
				reading <= bcd;
			// new events win over a clear
			key_sts  <= (key_sts & ~clr_bits[3:0]) | press;
			nack_sts <= (nack_sts & ~clr_bits[8]) | (sample.done & sample.nack);
		end
	end

	always_comb begin
		case (axil_req.araddr)
			`REG_CTRL:    rd_mux = {29'd0, ctrl};
			`REG_DISP_LO: rd_mux = disp_lo;
			`REG_DISP_HI: rd_mux = disp_hi;
			`REG_SAMPLE:  rd_mux = {12'd0, reading, raw_q};
			`REG_STATUS:  rd_mux = {23'd0, nack_sts, 4'd0, key_sts};
			default:      rd_mux = 32'd0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (rd_acc)
			rdata_q <= rd_mux;
	end

endmodule

`default_nettype wire

/* adc_panel_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sensor panel top
// i2c adc reader, bcd converter, keys, display scan, register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module adc_panel_top
	import i2c_pkg::*;
	import panel_pkg::*;
(
	input  wire            sys_clk,
	input  wire            sys_rst_n,
	input  wire [3:0]      key_in,
	input  wire axil_req_t axil_req,
	output wire axil_rsp_t axil_rsp,
	output wire [7:0]      seg_number,
	output wire [7:0]      seg_choice,
	output wire            scl,
	inout  wire            sda
);

	i2c_pins_t   pins;
	adc_sample_t sample;
	bcd3_t       bcd;
	logic        bcd_valid;
	key_evt_t    press;
	ctrl_t       ctrl;
	disp_word_u  user_word;
	bcd3_t       reading;

	// open-drain pads, the pullups live on the board
	assign scl = pins.scl_oe ? 1'b0 : 1'bz;
	assign sda = pins.sda_oe ? 1'b0 : 1'bz;

	i2c_adc_reader i2c_adc_reader_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.poll_en   (ctrl.poll_en),
		.sda_in    (sda),
		.pins      (pins),
		.sample    (sample)
	);

	reading_to_bcd reading_to_bcd_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.raw       (sample.raw),
		.start     (sample.done),
		.bcd       (bcd),
		.valid     (bcd_valid)
	);

	key_debounce key_debounce_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.press     (press)
	);

	seg_scan seg_scan_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.ctrl       (ctrl),
		.user_word  (user_word),
		.reading    (reading),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	panel_regs panel_regs_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.sample    (sample),
		.bcd       (bcd),
		.bcd_valid (bcd_valid),
		.press     (press),
		.ctrl      (ctrl),
		.user_word (user_word),
		.reading   (reading)
	);

endmodule

`default_nettype wire

/* tb_i2c_adc_model.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// behavioral i2c adc slave
// answers reads with bytes and ack choices queued by the testbench
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "panel_consts.svh"

module tb_i2c_adc_model (
	input  wire       scl,
	inout  wire       sda,
	input  wire       load,
	input  wire [7:0] load_byte,
	input  wire       load_ack
);

	// ack flag in bit 8, data byte below
	logic [8:0] queue_q [$];
	logic [8:0] cur;
	logic [7:0] addr_shift;
	logic       active;
	logic       acked;
	logic       sda_low;
	int         rises;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		cur        = 9'h0ff;
		addr_shift = 8'h00;
		active     = 1'b0;
		acked      = 1'b0;
		sda_low    = 1'b0;
		rises      = 0;
	end

	always @(posedge load)
		queue_q.push_back({load_ack, load_byte});

	// start condition, sda falls while scl is high
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active  = 1'b1;
			acked   = 1'b0;
			sda_low = 1'b0;
			rises   = 0;
			// empty queue means no ack
			cur     = (queue_q.size() > 0) ? queue_q.pop_front() : 9'h0ff;
		end
	end

	// stop condition
	always @(posedge sda) begin
		if (scl === 1'b1) begin
			active  = 1'b0;
			sda_low = 1'b0;
		end
	end

	always @(posedge scl) begin
		if (active) begin
			rises = rises + 1;
			if (rises <= 8)
				addr_shift = {addr_shift[6:0], sda};
		end
	end

	// sda only moves while scl is low
	always @(negedge scl) begin
		if (active) begin
			if (rises == 8) begin
				acked   = cur[8] && (addr_shift == {`ADC_DEV_ADDR, 1'b1});
				sda_low = acked;
			end else if (acked && rises >= 9 && rises <= 16) begin
				sda_low = ~cur[16 - rises];
			end else begin
				sda_low = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_adc_panel.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sensor panel testbench
// table of adc bytes and display modes, axi4-lite access, key presses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "panel_consts.svh"

module tb_adc_panel
	import panel_pkg::*;
();

	// mode 0 decimal, 1 user hex, 2 raw segments
	typedef struct packed {
		logic [7:0] adc;
		logic       ack;
		logic [1:0] mode;
	} row_t;

	localparam int NUM_ROWS    = 6;
	localparam int ROW_CYCLES  = `POLL_CYCLES + 80 * `I2C_DIV + 400;
	localparam int KEY_CYCLES  = 4 * (4 * `DEBOUNCE_CYCLES + 100);
	localparam int WATCHDOG_NS = (NUM_ROWS * ROW_CYCLES + KEY_CYCLES + 2000) * 20;

	logic        sys_clk;
	logic        sys_rst_n;
	logic [3:0]  key_in;
	axil_req_t   axil_req;
	axil_rsp_t   axil_rsp;
	wire  [7:0]  seg_number;
	wire  [7:0]  seg_choice;
	wire         scl;
	wire         sda;
	logic        load;
	logic [7:0]  load_byte;
	logic        load_ack;
	row_t        rows [NUM_ROWS];
	logic [7:0]  seg_tab [16];
	logic [7:0]  last_raw;
	logic [63:0] word;
	int          errors;
	int          checks;

	pullup (scl);
	pullup (sda);

	adc_panel_top adc_panel_top_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.scl        (scl),
		.sda        (sda)
	);

	tb_i2c_adc_model tb_i2c_adc_model_inst (
		.scl       (scl),
		.sda       (sda),
		.load      (load),
		.load_byte (load_byte),
		.load_ack  (load_ack)
	);

	initial sys_clk = 1'b0;
	always #10 sys_clk = ~sys_clk;

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("errors=%0d checks=%0d", errors + 1, checks);
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [11:0] decimal_digits(input logic [7:0] value);
		return {4'(value / 100), 4'((value / 10) % 10), 4'(value % 10)};
	endfunction

	function automatic logic [63:0] expected_segs(input logic [1:0] mode,
		input logic [63:0] w, input logic [7:0] raw);
		logic [63:0] segs;
		segs = w;
		if (mode == 2'd0) begin
			segs = {40'hff_ffff_ffff, (raw < 8'd100) ? 8'hff : seg_tab[raw / 100],
				seg_tab[(raw / 10) % 10], seg_tab[raw % 10]};
		end else if (mode == 2'd1) begin
			for (int d = 0; d < 8; d++)
				segs[8*d +: 8] = w[8*d + 7] ? 8'hff : seg_tab[w[8*d +: 4]];
		end
		return segs;
	endfunction

	task automatic axi_write(input logic [15:0] addr, input logic [31:0] data);
		int wait_cnt;
		@(negedge sys_clk);
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		@(posedge sys_clk);
		checks++;
		if (!axil_rsp.awready || !axil_rsp.wready) begin
			errors++;
			$display("write to address %h was not accepted", addr);
		end
		@(negedge sys_clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		wait_cnt = 0;
		while (!axil_rsp.bvalid && wait_cnt < 20) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		if (!axil_rsp.bvalid) begin
			errors++;
			$display("no write response for address %h", addr);
		end else if (axil_rsp.bresp !== 2'b00) begin
			errors++;
			$display("mismatch bresp got=%h expected=0", axil_rsp.bresp);
		end
	endtask

	task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
		int wait_cnt;
		@(negedge sys_clk);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		@(posedge sys_clk);
		checks++;
		if (!axil_rsp.arready) begin
			errors++;
			$display("read of address %h was not accepted", addr);
		end
		@(negedge sys_clk);
		axil_req.arvalid = 1'b0;
		wait_cnt = 0;
		while (!axil_rsp.rvalid && wait_cnt < 20) begin
			@(negedge sys_clk);
			wait_cnt++;
		end
		if (!axil_rsp.rvalid) begin
			errors++;
			$display("no read data for address %h", addr);
		end else if (axil_rsp.rresp !== 2'b00) begin
			errors++;
			$display("mismatch rresp got=%h expected=0", axil_rsp.rresp);
		end
		data = axil_rsp.rdata;
	endtask

	task automatic check_reg(input string name, input logic [15:0] addr,
		input logic [31:0] exp);
		logic [31:0] got;
		axi_read(addr, got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s got=%h expected=%h", name, got, exp);
		end
	endtask

	// walk the scan once, one compare per digit
	task automatic check_digits(input logic [63:0] exp);
		int         wait_cnt;
		logic [7:0] sel;
		for (int d = 0; d < 8; d++) begin
			sel = ~(8'h01 << d);
			wait_cnt = 0;
			while (seg_choice !== sel && wait_cnt < 16 * `SCAN_CYCLES) begin
				@(negedge sys_clk);
				wait_cnt++;
			end
			checks++;
			if (seg_choice !== sel) begin
				errors++;
				$display("digit %0d was never selected", d);
			end else if (seg_number !== exp[8*d +: 8]) begin
				errors++;
				$display("mismatch seg_number digit %0d got=%h expected=%h", d, seg_number,
					exp[8*d +: 8]);
			end
		end
	endtask

	// low for a while, then released long enough to settle
	task automatic drive_key(input int k, input int low_cycles);
		@(negedge sys_clk);
		key_in[k] = 1'b0;
		repeat (low_cycles) @(negedge sys_clk);
		key_in[k] = 1'b1;
		repeat (`DEBOUNCE_CYCLES + 8) @(negedge sys_clk);
	endtask

	initial begin
		int         wait_cnt;
		logic [2:0] ctrl_bits;
		errors    = 0;
		checks    = 0;
		void'($urandom(88546));
		sys_rst_n = 1'b0;
		key_in    = 4'hf;
		axil_req  = '0;
		axil_req.wstrb  = 4'hf;
		axil_req.bready = 1'b1;
		axil_req.rready = 1'b1;
		load      = 1'b0;
		load_byte = 8'h00;
		load_ack  = 1'b0;
		seg_tab = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
			8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};
		rows = '{'{8'd7, 1'b1, 2'd0}, '{8'd255, 1'b1, 2'd0}, '{8'd128, 1'b1, 2'd1},
			'{8'd99, 1'b0, 2'd0}, '{8'd42, 1'b1, 2'd2}, '{8'd100, 1'b1, 2'd0}};

		// no digit selected while in reset
		repeat (3) begin
			@(negedge sys_clk);
			checks++;
			if (seg_choice !== 8'hff) begin
				errors++;
				$display("mismatch seg_choice got=%h expected=ff", seg_choice);
			end
		end
		sys_rst_n = 1'b1;

		check_reg("ctrl", `REG_CTRL, 32'd0);
		check_reg("disp_lo", `REG_DISP_LO, 32'd0);
		check_reg("disp_hi", `REG_DISP_HI, 32'd0);
		check_reg("sample", `REG_SAMPLE, 32'd0);
		check_reg("status", `REG_STATUS, 32'd0);

		last_raw = 8'd0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			word = {$urandom, $urandom};
			ctrl_bits = {rows[r].mode == 2'd2, rows[r].mode != 2'd0, 1'b1};
			@(negedge sys_clk);
			load_byte = rows[r].adc;
			load_ack  = rows[r].ack;
			load      = 1'b1;
			@(negedge sys_clk);
			load = 1'b0;
			axi_write(`REG_DISP_LO, word[31:0]);
			axi_write(`REG_DISP_HI, word[63:32]);
			axi_write(`REG_CTRL, {29'd0, ctrl_bits});
			wait_cnt = 0;
			while (!adc_panel_top_inst.sample.done && wait_cnt < ROW_CYCLES) begin
				@(negedge sys_clk);
				wait_cnt++;
			end
			if (!adc_panel_top_inst.sample.done) begin
				errors++;
				$display("no adc read finished for row %0d", r);
			end
			// converter takes 9 cycles, then the register latch
			repeat (12) @(negedge sys_clk);
			axi_write(`REG_CTRL, {29'd0, ctrl_bits & 3'b110});
			if (rows[r].ack)
				last_raw = rows[r].adc;
			check_reg("sample", `REG_SAMPLE, {12'd0, decimal_digits(last_raw), last_raw});
			check_reg("status", `REG_STATUS, rows[r].ack ? 32'd0 : 32'h100);
			axi_write(`REG_STATUS, 32'h100);
			check_digits(expected_segs(rows[r].mode, word, last_raw));
		end

		for (int k = 0; k < 4; k++) begin
			drive_key(k, 1 + $urandom % (`DEBOUNCE_CYCLES - 4));
			check_reg("status", `REG_STATUS, 32'd0);
			drive_key(k, `DEBOUNCE_CYCLES + 4 + $urandom % 16);
			check_reg("status", `REG_STATUS, 32'd1 << k);
			axi_write(`REG_STATUS, 32'd1 << k);
			check_reg("status", `REG_STATUS, 32'd0);
		end

		$display("errors=%0d checks=%0d", errors, checks);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+.
i2c_pkg.sv
panel_pkg.sv
i2c_adc_reader.sv
reading_to_bcd.sv
key_debounce.sv
seg_scan.sv
panel_regs.sv
adc_panel_top.sv
tb_i2c_adc_model.sv
tb_adc_panel.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_adc_panel
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
